/* Makefile */
# Verilator build and run for the OBI DMA shell testbench

VERILATOR ?= verilator
TOP       ?= obi_dma_tb
FILELIST  ?= obi_dma_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_STR  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/dma_pkg.sv */
// dma shared definitions
// bus widths, register map, constants and the struct types
// used by the register block and both OBI engines
package dma_pkg;

	localparam int addr_width      = 32;
	localparam int data_width      = 32;
	localparam int be_width        = 4;
	localparam int id_width        = 1; // transaction id
	localparam int reg_idx_width   = 10; // word index from addr[11:2]
	localparam int max_outstanding = 2; // per engine

	localparam logic [data_width-1:0] magic_value    = 32'h6943_4017;
	localparam logic [data_width-1:0] unmapped_value = 32'hdead_beef;
	localparam logic [data_width-1:0] len_reset      = 32'd4; // one word

	// register word indices
	localparam logic [reg_idx_width-1:0] reg_magic  = 10'd0;
	localparam logic [reg_idx_width-1:0] reg_read   = 10'd1; // wr starts read, rd newest word
	localparam logic [reg_idx_width-1:0] reg_data1  = 10'd2;
	localparam logic [reg_idx_width-1:0] reg_data2  = 10'd3;
	localparam logic [reg_idx_width-1:0] reg_length = 10'd4;
	localparam logic [reg_idx_width-1:0] reg_write  = 10'd5; // wr starts write
	localparam logic [reg_idx_width-1:0] reg_wdata  = 10'd6; // wr pushes word, rd status

	////////////////////////////////////////////////////////////////////
	// bus and command types
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                  req;
		logic [addr_width-1:0] addr;
		logic                  we;
		logic [data_width-1:0] wdata;
		logic [id_width-1:0]   aid;
	} sbr_req_t;

	typedef struct packed {
		logic                  gnt;
		logic                  rvalid;
		logic [data_width-1:0] rdata;
		logic [id_width-1:0]   rid;
	} sbr_rsp_t;

	typedef struct packed {
		logic                  req;
		logic [addr_width-1:0] addr;
		logic                  we;
		logic [be_width-1:0]   be;
		logic [data_width-1:0] wdata;
	} mgr_req_t;

	typedef struct packed {
		logic                  gnt;
		logic                  rvalid;
		logic [data_width-1:0] rdata;
	} mgr_rsp_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] addr; // byte address
		logic [data_width-1:0] len; // byte length
	} dma_cmd_t;

	typedef struct packed {
		logic                  valid;
		logic [data_width-1:0] data;
	} stream_word_t;

	typedef struct packed {
		logic read_idle;
		logic data_ready;
		logic cmd_ready;
	} status_t;

endpackage

/* hdl/dma_regs.sv */
// dma register block
// decodes software accesses, holds length and read history,
// answers one cycle after acceptance and pulses engine commands
`timescale 1ns/1ps

module dma_regs (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  dma_pkg::sbr_req_t     sbr_req_i,
	output dma_pkg::sbr_rsp_t     sbr_rsp_o,
	output dma_pkg::dma_cmd_t     rd_cmd_o,
	input  dma_pkg::stream_word_t rd_stream_i,
	input  logic                  rd_idle_i,
	output dma_pkg::dma_cmd_t     wr_cmd_o,
	output dma_pkg::stream_word_t wr_word_o,
	input  logic [1:0]            wr_status_i // {data_ready, cmd_ready}
);

	logic                                 accept;
	logic                                 wr_acc; // accepted write
	logic [dma_pkg::reg_idx_width-1:0]    req_idx;
	logic [dma_pkg::reg_idx_width-1:0]    rsp_idx;
	logic [dma_pkg::id_width-1:0]         rsp_id;
	logic                                 rsp_valid;
	logic [dma_pkg::data_width-1:0]       length_q;
	logic [dma_pkg::data_width-1:0]       wdata_q; // addr or data word
	logic [dma_pkg::data_width-1:0]       len_q;
	logic                                 rd_go_q, wr_go_q, word_go_q;
	logic [2:0][dma_pkg::data_width-1:0]  hist_q; // [0] newest
	logic [dma_pkg::data_width-1:0]       rdata;
	dma_pkg::status_t                     status;

	assign accept  = sbr_req_i.req; // always granted
	assign wr_acc  = accept & sbr_req_i.we;
	assign req_idx = sbr_req_i.addr[11:2];

	////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			rsp_valid <= 1'b0;
			length_q  <= dma_pkg::len_reset;
			rd_go_q   <= 1'b0;
			wr_go_q   <= 1'b0;
			word_go_q <= 1'b0;
		end else begin
			rsp_valid <= accept;
			if (wr_acc && req_idx == dma_pkg::reg_length)
				length_q <= sbr_req_i.wdata;
			rd_go_q   <= wr_acc && req_idx == dma_pkg::reg_read;
			wr_go_q   <= wr_acc && req_idx == dma_pkg::reg_write && wr_status_i[0];
			word_go_q <= wr_acc && req_idx == dma_pkg::reg_wdata;
		end
	end

	// payload, captured at acceptance
	always_ff @(posedge clk_i) begin
		if (accept) begin
			rsp_idx <= req_idx;
			rsp_id  <= sbr_req_i.aid;
			wdata_q <= sbr_req_i.wdata;
			len_q   <= length_q;
		end
	end

	// stream history, every word shifts
	always_ff @(posedge clk_i) begin
		if (rd_stream_i.valid) begin
			hist_q[2] <= hist_q[1];
			hist_q[1] <= hist_q[0];
			hist_q[0] <= rd_stream_i.data;
		end
	end

	// engine pulses share the one payload register
	assign rd_cmd_o  = '{valid: rd_go_q, addr: wdata_q, len: len_q};
	assign wr_cmd_o  = '{valid: wr_go_q, addr: wdata_q, len: len_q};
	assign wr_word_o = '{valid: word_go_q, data: wdata_q};

	assign status = '{read_idle: rd_idle_i, data_ready: wr_status_i[1],
		cmd_ready: wr_status_i[0]};

	always_comb begin
		case (rsp_idx)
			dma_pkg::reg_magic:  rdata = dma_pkg::magic_value;
			dma_pkg::reg_read:   rdata = hist_q[0];
			dma_pkg::reg_data1:  rdata = hist_q[1];
			dma_pkg::reg_data2:  rdata = hist_q[2];
			dma_pkg::reg_length: rdata = length_q;
			dma_pkg::reg_wdata:  rdata = {29'h0, status};
			default:             rdata = dma_pkg::unmapped_value;
		endcase
	end

	assign sbr_rsp_o = '{gnt: 1'b1, rvalid: rsp_valid, rdata: rdata, rid: rsp_id};

	// a read only starts on an idle read engine
	a_rd_cmd_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd_cmd_o.valid |-> rd_idle_i);

endmodule

/* hdl/obi_dma_top.sv */
// dma shell top
// register block plus one read and one write engine, each on its
// own OBI manager port
`timescale 1ns/1ps

module obi_dma_top (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  dma_pkg::sbr_req_t sbr_req_i,
	output dma_pkg::sbr_rsp_t sbr_rsp_o,
	output dma_pkg::mgr_req_t rd_mgr_req_o,
	input  dma_pkg::mgr_rsp_t rd_mgr_rsp_i,
	output dma_pkg::mgr_req_t wr_mgr_req_o,
	input  dma_pkg::mgr_rsp_t wr_mgr_rsp_i
);

	dma_pkg::dma_cmd_t     rd_cmd, wr_cmd;
	dma_pkg::stream_word_t rd_stream, wr_word;
	logic                  rd_idle;
	logic [1:0]            wr_status; // {data_ready, cmd_ready}

	dma_regs i_regs (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.sbr_req_i   (sbr_req_i),
		.sbr_rsp_o   (sbr_rsp_o),
		.rd_cmd_o    (rd_cmd),
		.rd_stream_i (rd_stream),
		.rd_idle_i   (rd_idle),
		.wr_cmd_o    (wr_cmd),
		.wr_word_o   (wr_word),
		.wr_status_i (wr_status)
	);

	obi_read_dma i_read_dma (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.cmd_i     (rd_cmd),
		.idle_o    (rd_idle),
		.mgr_req_o (rd_mgr_req_o),
		.mgr_rsp_i (rd_mgr_rsp_i),
		.stream_o  (rd_stream)
	);

	obi_write_dma i_write_dma (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.cmd_i     (wr_cmd),
		.word_i    (wr_word),
		.status_o  (wr_status),
		.mgr_req_o (wr_mgr_req_o),
		.mgr_rsp_i (wr_mgr_rsp_i)
	);

endmodule

/* hdl/obi_read_dma.sv */
// OBI read DMA engine
// issues aligned word reads over any byte range and realigns the
// returned bytes into a little-endian word stream starting at byte 0
`timescale 1ns/1ps

module obi_read_dma (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  dma_pkg::dma_cmd_t     cmd_i,
	output logic                  idle_o,
	output dma_pkg::mgr_req_t     mgr_req_o,
	input  dma_pkg::mgr_rsp_t     mgr_rsp_i,
	output dma_pkg::stream_word_t stream_o
);

	logic        start, issue;
	logic        busy, first_flag, last_flag;
	logic [31:0] rd_addr, byte_cnt;
	logic [1:0]  addr_lsb, len_lsb;
	logic [1:0]  oust; // requests in flight
	logic [3:0]  in_sum, out_sum;
	logic        double_last; // extra flush word at the end
	logic [3:0]  last_be;
	logic [31:0] last_mask;
	logic        tag_first, tag_last;

	assign start = cmd_i.valid & idle_o;
	assign issue = mgr_req_o.req & mgr_rsp_i.gnt;
	assign last_flag = ({1'b0, byte_cnt} + {31'h0, rd_addr[1:0]}) <= 33'd4;

	////////////////////////////////////////////////////////////////////
	// address generation
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			busy       <= 1'b0;
			first_flag <= 1'b0;
		end else if (start) begin
			busy       <= 1'b1;
			first_flag <= 1'b1;
		end else if (issue) begin
			first_flag <= 1'b0;
			if (last_flag)
				busy <= 1'b0; // range done
		end
	end

	always_ff @(posedge clk_i) begin
		if (start) begin
			rd_addr  <= cmd_i.addr;
			byte_cnt <= cmd_i.len;
			addr_lsb <= cmd_i.addr[1:0];
			len_lsb  <= cmd_i.len[1:0];
		end else if (issue && !last_flag) begin
			rd_addr  <= rd_addr + 32'd4; // lsb kept
			byte_cnt <= byte_cnt - 32'd4;
		end
	end

	// in and out word counts end in the same word, so one more out
	assign in_sum      = {2'b00, addr_lsb} + {2'b00, len_lsb} + 4'd3;
	assign out_sum     = {2'b00, len_lsb} + 4'd3;
	assign double_last = (addr_lsb != 2'd0) && (in_sum[3:2] == out_sum[3:2]);

	assign last_be   = (len_lsb == 2'd0) ? 4'b1111 : (4'b0001 << len_lsb) - 4'b0001;
	assign last_mask = {{8{last_be[3]}}, {8{last_be[2]}}, {8{last_be[1]}}, {8{last_be[0]}}};

	// throttle, req holds once raised since oust only drops
	assign mgr_req_o = '{req: busy && oust < dma_pkg::max_outstanding,
		addr: {rd_addr[31:2], 2'b00}, we: 1'b0, be: 4'hf, wdata: '0};

	always_ff @(posedge clk_i) begin
		if (!rst_ni)
			oust <= '0;
		else
			oust <= oust + {1'b0, issue} - {1'b0, mgr_rsp_i.rvalid};
	end

	read_tag_fifo i_tag_fifo (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.push_i  (issue),
		.first_i (first_flag),
		.last_i  (last_flag),
		.pop_i   (mgr_rsp_i.rvalid),
		.first_o (tag_first),
		.last_o  (tag_last)
	);

	////////////////////////////////////////////////////////////////////
	// realignment datapath
	////////////////////////////////////////////////////////////////////
	logic [6:0][7:0] in_reg; // new word in [6:3], prev top bytes in [2:0]
	logic            v0, f0, l0;
	logic            flush_pend;
	logic            emit_win, win_last;
	logic [31:0]     window, flush_word;
	dma_pkg::stream_word_t stream_q;

	always_ff @(posedge clk_i) begin
		if (mgr_rsp_i.rvalid) begin
			in_reg[6:3] <= mgr_rsp_i.rdata;
			in_reg[2:0] <= in_reg[6:4];
			f0          <= tag_first;
			l0          <= tag_last;
		end
	end

	always_comb begin
		case (addr_lsb)
			2'd0: window = in_reg[6:3];
			2'd1: window = in_reg[3:0];
			2'd2: window = in_reg[4:1];
			default: window = in_reg[5:2];
		endcase
		case (addr_lsb)
			2'd1: flush_word = {8'h0, in_reg[6:4]};
			2'd2: flush_word = {16'h0, in_reg[6:5]};
			2'd3: flush_word = {24'h0, in_reg[6]};
			default: flush_word = '0; // aligned never flushes
		endcase
	end

	assign emit_win = v0 && !(f0 && addr_lsb != 2'd0); // drop first partial
	assign win_last = l0 && !double_last;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			v0             <= 1'b0;
			flush_pend     <= 1'b0;
			stream_q.valid <= 1'b0;
		end else begin
			v0             <= mgr_rsp_i.rvalid;
			flush_pend     <= v0 && l0 && double_last;
			stream_q.valid <= emit_win || flush_pend;
		end
	end

	always_ff @(posedge clk_i) begin
		if (flush_pend)
			stream_q.data <= flush_word & last_mask;
		else if (emit_win)
			stream_q.data <= window & (win_last ? last_mask : 32'hffff_ffff);
	end

	assign stream_o = stream_q;
	assign idle_o   = !busy && oust == 2'd0 && !v0 && !flush_pend && !stream_q.valid;

	a_oust_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		oust <= dma_pkg::max_outstanding);

	a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mgr_req_o.req && !mgr_rsp_i.gnt |=> mgr_req_o.req && $stable(mgr_req_o.addr));

endmodule

/* hdl/obi_write_dma.sv */
// OBI write DMA engine
// takes byte-0 aligned input words and stores them at any byte
// address and length with first/last byte enables
`timescale 1ns/1ps

module obi_write_dma (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  dma_pkg::dma_cmd_t     cmd_i,
	input  dma_pkg::stream_word_t word_i,
	output logic [1:0]            status_o, // {data_ready, cmd_ready}
	output dma_pkg::mgr_req_t     mgr_req_o,
	input  dma_pkg::mgr_rsp_t     mgr_rsp_i
);

	logic        start, issue;
	logic        cmd_ready, data_ready;
	logic        busy, take_word, need_flush;
	logic [32:0] out_span, in_span;
	logic [31:0] wr_cnt; // writes left
	logic [31:0] in_cnt; // input words left
	logic        ready_w; // datapath holds the next write
	logic        flush_q; // double-last write from held bytes
	logic        first_flag, last_flag;
	logic [31:0] wr_addr;
	logic [1:0]  addr_lsb, end_lsb;
	logic [3:0]  first_be, last_be, be;
	logic [1:0]  oust;

	assign start = cmd_i.valid & cmd_ready;
	assign issue = mgr_req_o.req & mgr_rsp_i.gnt;

	// word counts of the command
	assign out_span = {1'b0, cmd_i.len} + {31'h0, cmd_i.addr[1:0]} + 33'd3;
	assign in_span  = {1'b0, cmd_i.len} + 33'd3;
	assign end_lsb  = cmd_i.addr[1:0] + cmd_i.len[1:0];

	assign busy       = wr_cnt != '0;
	assign data_ready = busy && !ready_w && in_cnt != '0;
	assign take_word  = word_i.valid && data_ready; // lost otherwise
	assign need_flush = busy && !ready_w && in_cnt == '0;
	assign cmd_ready  = !busy && oust == 2'd0; // all writes answered
	assign status_o   = {data_ready, cmd_ready};

	////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_cnt     <= '0;
			in_cnt     <= '0;
			ready_w    <= 1'b0;
			flush_q    <= 1'b0;
			first_flag <= 1'b0;
		end else if (start) begin
			wr_cnt     <= (cmd_i.len == '0) ? '0 : {1'b0, out_span[32:2]};
			in_cnt     <= {1'b0, in_span[32:2]};
			first_flag <= 1'b1;
		end else if (issue) begin
			ready_w    <= 1'b0;
			wr_cnt     <= wr_cnt - 32'd1;
			first_flag <= 1'b0;
		end else if (take_word) begin
			ready_w <= 1'b1;
			in_cnt  <= in_cnt - 32'd1;
			flush_q <= 1'b0;
		end else if (need_flush) begin
			ready_w <= 1'b1; // second last, no new word
			flush_q <= 1'b1;
		end
	end

	// byte enables and address, latched at the command
	always_ff @(posedge clk_i) begin
		if (start) begin
			wr_addr  <= {cmd_i.addr[31:2], 2'b00};
			addr_lsb <= cmd_i.addr[1:0];
			first_be <= 4'b1111 << cmd_i.addr[1:0];
			last_be  <= (end_lsb == 2'd0) ? 4'b1111 : (4'b0001 << end_lsb) - 4'b0001;
		end else if (issue) begin
			wr_addr <= wr_addr + 32'd4;
		end
	end

	assign last_flag = wr_cnt == 32'd1;
	assign be = (first_flag && last_flag) ? first_be & last_be :
		first_flag ? first_be :
		last_flag  ? last_be : 4'b1111;

	////////////////////////////////////////////////////////////////////
	// realignment datapath
	////////////////////////////////////////////////////////////////////
	logic [6:0][7:0] in_reg; // new word [6:3], prev top bytes [2:0]
	logic [31:0]     write_data;

	always_ff @(posedge clk_i) begin
		if (take_word) begin
			in_reg[6:3] <= word_i.data;
			in_reg[2:0] <= in_reg[6:4];
		end
	end

	always_comb begin
		if (flush_q) begin
			case (addr_lsb)
				2'd1: write_data = {24'h0, in_reg[6]};
				2'd2: write_data = {16'h0, in_reg[6:5]};
				default: write_data = {8'h0, in_reg[6:4]};
			endcase
		end else begin
			case (addr_lsb)
				2'd0: write_data = in_reg[6:3];
				2'd1: write_data = in_reg[5:2];
				2'd2: write_data = in_reg[4:1];
				default: write_data = in_reg[3:0];
			endcase
		end
	end

	assign mgr_req_o = '{req: ready_w && oust < dma_pkg::max_outstanding,
		addr: wr_addr, we: 1'b1, be: be, wdata: write_data};

	// writes in flight, throttle and completion
	always_ff @(posedge clk_i) begin
		if (!rst_ni)
			oust <= '0;
		else
			oust <= oust + {1'b0, issue} - {1'b0, mgr_rsp_i.rvalid};
	end

	a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mgr_req_o.req |-> mgr_req_o.be != '0);

endmodule

/* hdl/read_tag_fifo.sv */
// read tag queue
// holds first/last flags of issued reads until their data returns
`timescale 1ns/1ps

module read_tag_fifo (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic push_i,
	input  logic first_i,
	input  logic last_i,
	input  logic pop_i,
	output logic first_o,
	output logic last_o
);

	logic [2:0][1:0] mem_q; // {first, last}
	logic [1:0]      wr_ptr, rd_ptr;
	logic [1:0]      count;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == 2'd2) ? 2'd0 : wr_ptr + 2'd1; // wrap at 3
			if (pop_i)
				rd_ptr <= (rd_ptr == 2'd2) ? 2'd0 : rd_ptr + 2'd1;
			count <= count + {1'b0, push_i} - {1'b0, pop_i};
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i)
			mem_q[wr_ptr] <= {first_i, last_i};
	end

	assign {first_o, last_o} = mem_q[rd_ptr]; // head entry

	a_no_underflow_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(pop_i && count == 2'd0) && !(push_i && !pop_i && count == 2'd3));

endmodule

/* obi_dma_top.f */
hdl/dma_pkg.sv
hdl/read_tag_fifo.sv
hdl/obi_read_dma.sv
hdl/obi_write_dma.sv
hdl/dma_regs.sv
hdl/obi_dma_top.sv
verif/obi_dma_tb.sv

/* verif/obi_dma_tb.sv */
// OBI DMA shell testbench
// file-driven register sequencer, two byte-addressed OBI memory
// models with random grant and delayed in-order rvalid
`timescale 1ns/1ps

module obi_mem_model (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  dma_pkg::mgr_req_t req_i,
	output dma_pkg::mgr_rsp_t rsp_o
);

	logic [7:0]  mem [0:4095]; // addr[11:0] window
	logic [31:0] data_q [$]; // pending responses, in order
	int unsigned due_q [$];
	int unsigned cyc, last_due, due;
	integer      seed;
	logic        gnt_q, rvalid_q;
	logic [31:0] rdata_q, word;

	initial begin
		seed     = 32027;
		gnt_q    = 1'b0;
		rvalid_q = 1'b0;
		rdata_q  = '0;
		for (int a = 0; a < 4096; a++)
			mem[a] = 8'(a * 7 + 3); // low byte of a*7+3
	end

	always @(posedge clk_i) begin
		if (!rst_ni) begin
			gnt_q    <= 1'b0;
			rvalid_q <= 1'b0;
			cyc      = 0;
			last_due = 0;
			data_q.delete();
			due_q.delete();
		end else begin
			rvalid_q <= 1'b0;
			if (due_q.size() != 0 && due_q[0] <= cyc) begin
				rvalid_q <= 1'b1;
				rdata_q  <= data_q.pop_front();
				void'(due_q.pop_front());
			end
			if (req_i.req && gnt_q) begin
				word = '0; // writes answer with zero
				for (int b = 0; b < 4; b++) begin
					if (!req_i.we)
						word[8*b +: 8] = mem[{req_i.addr[11:2], 2'(b)}];
					else if (req_i.be[b])
						mem[{req_i.addr[11:2], 2'(b)}] = req_i.wdata[8*b +: 8];
				end
				due = cyc + 1 + $unsigned($random(seed)) % 3; // 1..3 cycles
				if (due <= last_due)
					due = last_due + 1; // in order
				last_due = due;
				data_q.push_back(word);
				due_q.push_back(due);
			end
			gnt_q <= ($random(seed) & 3) != 0; // granted 3 of 4 cycles
			cyc = cyc + 1;
		end
	end

	assign rsp_o = '{gnt: gnt_q, rvalid: rvalid_q, rdata: rdata_q};

endmodule

module obi_dma_tb;

	localparam int max_ops   = 64;
	localparam int timeout   = 50; // cycles per handshake
	localparam int max_polls = 200;

	logic                  clk_i, rst_ni;
	dma_pkg::sbr_req_t     sbr_req;
	dma_pkg::sbr_rsp_t     sbr_rsp;
	dma_pkg::mgr_req_t     rd_req, wr_req;
	dma_pkg::mgr_rsp_t     rd_rsp, wr_rsp;
	logic [31:0]           tests [0:4*max_ops-1]; // op, arg, value, expected
	logic [dma_pkg::id_width-1:0] aid_q;
	int                    mismatch_cnt, timeout_cnt, fault_cnt;

	obi_dma_top i_dut (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.sbr_req_i    (sbr_req),
		.sbr_rsp_o    (sbr_rsp),
		.rd_mgr_req_o (rd_req),
		.rd_mgr_rsp_i (rd_rsp),
		.wr_mgr_req_o (wr_req),
		.wr_mgr_rsp_i (wr_rsp)
	);

	obi_mem_model i_rd_mem (.clk_i(clk_i), .rst_ni(rst_ni), .req_i(rd_req), .rsp_o(rd_rsp));
	obi_mem_model i_wr_mem (.clk_i(clk_i), .rst_ni(rst_ni), .req_i(wr_req), .rsp_o(wr_rsp));

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i; // 10 ns
	end

	//////////////////////////////////////////////////////////////////////
	// register port access, one request then its response
	//////////////////////////////////////////////////////////////////////
	task automatic reg_access(input logic we, input logic [31:0] idx, input logic [31:0] wdata,
		output dma_pkg::sbr_rsp_t rsp, output logic [dma_pkg::id_width-1:0] id, output logic ok);
		int cnt;
		ok = 1'b1;
		id = aid_q;
		@(posedge clk_i);
		sbr_req <= '{req: 1'b1, addr: {idx[29:0], 2'b00}, we: we, wdata: wdata, aid: aid_q};
		cnt = 0;
		@(negedge clk_i);
		while (!sbr_rsp.gnt && cnt < timeout) begin
			@(negedge clk_i);
			cnt++;
		end
		if (!sbr_rsp.gnt) begin
			timeout_cnt++;
			$display("timeout: register port never granted the request to index %0d", idx);
			ok = 1'b0;
		end
		@(posedge clk_i); // accepted here
		sbr_req.req <= 1'b0;
		aid_q = ~aid_q;
		cnt = 0;
		@(negedge clk_i);
		while (ok && !sbr_rsp.rvalid && cnt < timeout) begin
			@(negedge clk_i);
			cnt++;
		end
		if (ok && !sbr_rsp.rvalid) begin
			timeout_cnt++;
			$display("timeout: no register response for index %0d", idx);
			ok = 1'b0;
		end
		rsp = sbr_rsp;
	endtask

	task automatic check_rsp(input dma_pkg::sbr_rsp_t got, input dma_pkg::sbr_rsp_t exp,
		input logic [31:0] idx);
		if (got.rdata !== exp.rdata) begin
			mismatch_cnt++;
			$display("mismatch sbr_rsp_o.rdata reg %0d: got %h, expected %h",
				idx, got.rdata, exp.rdata);
		end
		if (got.rid !== exp.rid) begin
			mismatch_cnt++;
			$display("mismatch sbr_rsp_o.rid reg %0d: got %h, expected %h", idx, got.rid, exp.rid);
		end
	endtask

	task automatic check_mem(input logic [7:0] got, input logic [7:0] exp, input string name,
		input logic [31:0] addr);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s[%h]: got %h, expected %h", name, addr, got, exp);
		end
	endtask

	// poll the status register until the masked bits match
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] exp, output logic ok);
		dma_pkg::sbr_rsp_t            rsp;
		logic [dma_pkg::id_width-1:0] id;
		int                           polls;
		polls = 0;
		do begin
			reg_access(1'b0, 32'(dma_pkg::reg_wdata), '0, rsp, id, ok);
			polls++;
		end while (ok && (rsp.rdata & mask) != exp && polls < max_polls);
		if (ok && (rsp.rdata & mask) != exp) begin
			timeout_cnt++;
			$display("timeout: status bits %h never reached %h", mask, exp);
			ok = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////////////
	initial begin
		dma_pkg::sbr_rsp_t            rsp, exp_rsp;
		logic [dma_pkg::id_width-1:0] id;
		logic                         ok, done;
		logic [31:0]                  op, arg, val, exp;
		logic [7:0]                   mem_byte;
		int                           i;
		rst_ni       = 1'b0;
		sbr_req      = '0;
		aid_q        = '0;
		mismatch_cnt = 0;
		timeout_cnt  = 0;
		fault_cnt    = 0;
		for (i = 0; i < 4 * max_ops; i++)
			tests[i] = '0; // unloaded entries end the run
		$readmemh("verif/obi_dma_tests.txt", tests);
		if (tests[0] == '0) begin
			fault_cnt++;
			$display("no operations were loaded from the test file");
		end
		repeat (4) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		if (sbr_rsp.rvalid || rd_req.req || wr_req.req) begin
			fault_cnt++;
			$display("outputs are not idle after reset");
		end
		done = 1'b0;
		i    = 0;
		while (!done && i < max_ops) begin
			op  = tests[4*i];
			arg = tests[4*i+1];
			val = tests[4*i+2];
			exp = tests[4*i+3];
			ok  = 1'b1;
			case (op)
				32'd0: done = 1'b1;
				32'd1: reg_access(1'b1, arg, val, rsp, id, ok);
				32'd2: begin
					reg_access(1'b0, arg, '0, rsp, id, ok);
					exp_rsp = '{gnt: 1'b1, rvalid: 1'b1, rdata: exp, rid: id};
					if (ok)
						check_rsp(rsp, exp_rsp, arg);
				end
				32'd3: wait_status(val, exp, ok);
				32'd4: begin
					mem_byte = val[0] ? i_wr_mem.mem[arg[11:0]] : i_rd_mem.mem[arg[11:0]];
					check_mem(mem_byte, exp[7:0], val[0] ? "wr_mem" : "rd_mem", arg);
				end
				default: begin
					fault_cnt++;
					$display("unknown operation code %h in test line %0d", op, i);
				end
			endcase
			if (!ok)
				done = 1'b1; // a stuck handshake ends the run
			i++;
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d other",
			mismatch_cnt, timeout_cnt, fault_cnt);
		if (mismatch_cnt + timeout_cnt + fault_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* verif/obi_dma_tests.txt */
// columns: op, register index or byte address, value, expected (all hex)
// op 1 reg write, 2 reg read compare, 3 wait status (value is mask), 4 mem byte (value 1 = write mem), 0 end
2 0 0 69434017 // magic
2 5 0 deadbeef // unmapped
2 7 0 deadbeef
2 4 0 4 // length after reset
1 4 c 0
2 4 0 c
1 1 100 0 // aligned read, 12 bytes
3 6 4 4 // read_idle
2 1 0 5049423b
2 2 0 342d261f
2 3 0 18110a03
1 4 6 0
1 1 101 0 // unaligned read, 6 bytes
3 6 4 4
2 1 0 00002d26 // zero above byte 1
2 2 0 1f18110a
2 3 0 5049423b
3 6 1 1 // cmd_ready
1 5 203 0 // unaligned write, 6 bytes
3 6 2 2 // data_ready
1 6 a4a3a2a1 0
3 6 2 2
1 6 b4b3b2b1 0
3 6 1 1 // write finished
4 202 1 11 // pattern kept
4 203 1 a1
4 204 1 a2
4 205 1 a3
4 206 1 a4
4 207 1 b1
4 208 1 b2
4 209 1 42 // pattern kept
0 0 0 0
